/* src/ppu_cfg.svh */
// PPU build-time sizes and APB register map
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// --------------------
// Datapath sizes

`define PPU_W_COORD       12
`define PPU_W_ADDR        16
`define PPU_W_DATA        32
`define PPU_W_PADDR       16
`define PPU_PXFIFO_DEPTH  8

// --------------------
// Register offsets

`define PPU_REG_CSR         16'h0000
`define PPU_REG_DISPSIZE    16'h0004
`define PPU_REG_DEFAULT_BG  16'h0008
`define PPU_REG_BG_CSR      16'h000c
`define PPU_REG_SCROLL      16'h0010
`define PPU_REG_TSBASE      16'h0014
`define PPU_REG_TMBASE      16'h0018
`define PPU_REG_PXFIFO      16'h001c
`define PPU_REG_BEAM        16'h0020

`endif

/* src/ppu_pkg.sv */
// PPU shared types for coordinates, pixels, addresses and register fields
`include "ppu_cfg.svh"

package ppu_pkg;

typedef logic [`PPU_W_COORD-1:0] coord_t;
typedef logic [`PPU_W_ADDR-1:0]  mem_addr_t;
typedef logic [3:0]              log_size_t;
typedef logic [$clog2(`PPU_PXFIFO_DEPTH + 1)-1:0] fifo_level_t;

// Tileset colour, 5 bits per channel
typedef struct packed {
	logic [4:0] r;
	logic [4:0] g;
	logic [4:0] b;
} rgb_t;

typedef struct packed {
	logic alpha;
	rgb_t colour;
} rgb555_t;

// Panel format, green has one extra bit
typedef struct packed {
	logic [4:0] r;
	logic [5:0] g;
	logic [4:0] b;
} lcd_pix_t;

// CSR bits 5:0
typedef struct packed {
	logic lcd_dc;
	logic lcd_cs;
	logic halt_vsync;
	logic running;
	logic halt;
	logic run;
} csr_t;

// BG_CSR bits 11:0
typedef struct packed {
	log_size_t  log_h;
	log_size_t  log_w;
	logic [2:0] rsvd;
	logic       en;
} bg_csr_t;

// PXFIFO status read, bits 6:0
typedef struct packed {
	logic        tx_busy;
	logic        full;
	logic        empty;
	fifo_level_t level;
} pxfifo_stat_t;

endpackage

/* src/ppu_cfg_if.sv */
// Background and display configuration bundle driven by the register block
interface ppu_cfg_if import ppu_pkg::*; ();

// Background layer
logic      bg_en;
coord_t    scroll_x;
coord_t    scroll_y;
log_size_t log_w;
log_size_t log_h;
mem_addr_t tsbase;
mem_addr_t tmbase;
rgb_t      default_bg;

// Display raster
coord_t    disp_w;
coord_t    disp_h;
logic      halt_vsync;

modport regs (
	output bg_en, scroll_x, scroll_y, log_w, log_h, tsbase, tmbase, default_bg,
	output disp_w, disp_h, halt_vsync
);

modport bg (
	input bg_en, scroll_x, scroll_y, log_w, log_h, tsbase, tmbase, default_bg
);

modport raster (
	input disp_w, disp_h, halt_vsync
);

endinterface

/* src/ppu_regs.sv */
// APB slave with PPU configuration registers, command pulses and status reads
`include "ppu_cfg.svh"

module ppu_regs import ppu_pkg::*; (
	input  logic                   clk_ppu,
	input  logic                   rst_n_ppu,
	input  logic                   apb_psel_i,
	input  logic                   apb_penable_i,
	input  logic                   apb_pwrite_i,
	input  logic [`PPU_W_PADDR-1:0] apb_paddr_i,
	input  logic [`PPU_W_DATA-1:0] apb_pwdata_i,
	output logic [`PPU_W_DATA-1:0] apb_prdata_o,
	output logic                   apb_pready_o,
	output logic                   apb_pslverr_o,
	ppu_cfg_if.regs                cfg,
	output logic                   run_o,
	output logic                   halt_o,
	input  logic                   running_i,
	input  coord_t                 beam_x_i,
	input  coord_t                 beam_y_i,
	output logic                   direct_vld_o,
	output lcd_pix_t               direct_pix_o,
	input  fifo_level_t            fifo_level_i,
	input  logic                   tx_busy_i,
	output logic                   lcd_cs_o,
	output logic                   lcd_dc_o
);

logic         acc;
logic         wen;
logic         hit;
csr_t         csr_wr;
csr_t         csr_rd;
bg_csr_t      bg_wr;
bg_csr_t      bg_rd;
pxfifo_stat_t stat;

// Zero-wait slave, every access completes in its first access cycle
assign acc = apb_psel_i && apb_penable_i;
assign wen = acc && apb_pwrite_i;
assign apb_pready_o = 1'b1;
assign apb_pslverr_o = acc && !hit;

assign csr_wr = csr_t'(apb_pwdata_i[5:0]);
assign bg_wr = bg_csr_t'(apb_pwdata_i[11:0]);

// --------------------
// Command pulses

assign run_o  = wen && apb_paddr_i == `PPU_REG_CSR && csr_wr.run;
assign halt_o = wen && apb_paddr_i == `PPU_REG_CSR && csr_wr.halt;

assign direct_vld_o = wen && apb_paddr_i == `PPU_REG_PXFIFO;
assign direct_pix_o = lcd_pix_t'(apb_pwdata_i[15:0]);

// --------------------
// Configuration registers

always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		cfg.bg_en <= 1'b0;
		cfg.scroll_x <= '0;
		cfg.scroll_y <= '0;
		cfg.log_w <= '0;
		cfg.log_h <= '0;
		cfg.tsbase <= '0;
		cfg.tmbase <= '0;
		cfg.default_bg <= '0;
		cfg.disp_w <= '0;
		cfg.disp_h <= '0;
		cfg.halt_vsync <= 1'b0;
		lcd_cs_o <= 1'b1;
		lcd_dc_o <= 1'b0;
	end else if (wen) begin
		case (apb_paddr_i)
		`PPU_REG_CSR: begin
			cfg.halt_vsync <= csr_wr.halt_vsync;
			lcd_cs_o <= csr_wr.lcd_cs;
			lcd_dc_o <= csr_wr.lcd_dc;
		end
		`PPU_REG_DISPSIZE: begin
			cfg.disp_w <= apb_pwdata_i[`PPU_W_COORD-1:0];
			cfg.disp_h <= apb_pwdata_i[16 +: `PPU_W_COORD];
		end
		`PPU_REG_DEFAULT_BG: cfg.default_bg <= apb_pwdata_i[14:0];
		`PPU_REG_BG_CSR: begin
			cfg.bg_en <= bg_wr.en;
			cfg.log_w <= bg_wr.log_w;
			cfg.log_h <= bg_wr.log_h;
		end
		`PPU_REG_SCROLL: begin
			cfg.scroll_x <= apb_pwdata_i[`PPU_W_COORD-1:0];
			cfg.scroll_y <= apb_pwdata_i[16 +: `PPU_W_COORD];
		end
		`PPU_REG_TSBASE: cfg.tsbase <= apb_pwdata_i[`PPU_W_ADDR-1:0];
		`PPU_REG_TMBASE: cfg.tmbase <= apb_pwdata_i[`PPU_W_ADDR-1:0];
		default: ;
		endcase
	end
end

// --------------------
// Read mux

always_comb begin
	csr_rd = '{lcd_dc: lcd_dc_o, lcd_cs: lcd_cs_o, halt_vsync: cfg.halt_vsync,
		running: running_i, halt: 1'b0, run: 1'b0};
	bg_rd = '{log_h: cfg.log_h, log_w: cfg.log_w, rsvd: 3'b000, en: cfg.bg_en};
	stat.tx_busy = tx_busy_i;
	stat.full = fifo_level_i == fifo_level_t'(`PPU_PXFIFO_DEPTH);
	stat.empty = fifo_level_i == '0;
	stat.level = fifo_level_i;
end

always_comb begin
	hit = 1'b1;
	apb_prdata_o = '0;
	case (apb_paddr_i)
	`PPU_REG_CSR: apb_prdata_o[5:0] = csr_rd;
	`PPU_REG_DISPSIZE: begin
		apb_prdata_o[`PPU_W_COORD-1:0] = cfg.disp_w;
		apb_prdata_o[16 +: `PPU_W_COORD] = cfg.disp_h;
	end
	`PPU_REG_DEFAULT_BG: apb_prdata_o[14:0] = cfg.default_bg;
	`PPU_REG_BG_CSR: apb_prdata_o[11:0] = bg_rd;
	`PPU_REG_SCROLL: begin
		apb_prdata_o[`PPU_W_COORD-1:0] = cfg.scroll_x;
		apb_prdata_o[16 +: `PPU_W_COORD] = cfg.scroll_y;
	end
	`PPU_REG_TSBASE: apb_prdata_o[`PPU_W_ADDR-1:0] = cfg.tsbase;
	`PPU_REG_TMBASE: apb_prdata_o[`PPU_W_ADDR-1:0] = cfg.tmbase;
	`PPU_REG_PXFIFO: apb_prdata_o[6:0] = stat;
	`PPU_REG_BEAM: begin
		apb_prdata_o[`PPU_W_COORD-1:0] = beam_x_i;
		apb_prdata_o[16 +: `PPU_W_COORD] = beam_y_i;
	end
	default: hit = 1'b0;
	endcase
end

endmodule

/* src/ppu_raster_counter.sv */
// Run and halt control with beam position tracking over the display raster
module ppu_raster_counter import ppu_pkg::*; (
	input  logic      clk_ppu,
	input  logic      rst_n_ppu,
	ppu_cfg_if.raster cfg,
	input  logic      run_i,
	input  logic      halt_i,
	input  logic      step_i,
	output logic      running_o,
	output coord_t    beam_x_o,
	output coord_t    beam_y_o
);

logic adv;
logic row_end;
logic frame_end;

// Beam only moves for pixels accepted while running
assign adv = step_i && running_o;
assign row_end = adv && beam_x_o == cfg.disp_w - 1'b1;
assign frame_end = row_end && beam_y_o == cfg.disp_h - 1'b1;

// Halt wins over run when both are written together
always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		running_o <= 1'b0;
	end else if (halt_i || (cfg.halt_vsync && frame_end)) begin
		running_o <= 1'b0;
	end else if (run_i) begin
		running_o <= 1'b1;
	end
end

always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		beam_x_o <= '0;
		beam_y_o <= '0;
	end else if (run_i) begin
		beam_x_o <= '0;
		beam_y_o <= '0;
	end else if (frame_end) begin
		beam_x_o <= '0;
		beam_y_o <= '0;
	end else if (row_end) begin
		beam_x_o <= '0;
		beam_y_o <= beam_y_o + 1'b1;
	end else if (adv) begin
		beam_x_o <= beam_x_o + 1'b1;
	end
end

endmodule

/* src/ppu_background.sv */
// Tile background fetch with scroll wrap and default-colour fill
module ppu_background import ppu_pkg::*; (
	input  logic        clk_ppu,
	input  logic        rst_n_ppu,
	ppu_cfg_if.bg       cfg,
	input  logic        running_i,
	input  coord_t      beam_x_i,
	input  coord_t      beam_y_i,
	output logic        mem_req_vld_o,
	input  logic        mem_req_rdy_i,
	output mem_addr_t   mem_addr_o,
	input  logic        mem_rsp_vld_i,
	input  logic [15:0] mem_rdata_i,
	output logic        pix_vld_o,
	input  logic        pix_rdy_i,
	output rgb555_t     pix_o
);

typedef enum logic [1:0] {
	S_MAP,
	S_TILE,
	S_OUT
} bg_state_e;

bg_state_e state;
logic      rsp_wait;
logic      start;
logic      map_rsp;
logic      tile_rsp;
coord_t    mask_w;
coord_t    mask_h;
coord_t    px;
coord_t    py;
mem_addr_t map_idx;
mem_addr_t map_addr;
mem_addr_t tile_addr;
logic [2:0] fine_x_q;
logic [2:0] fine_y_q;
rgb555_t   tile_px;

// --------------------
// Playfield position

// Playfield is 8 << log pixels on each axis, always a power of two
assign mask_w = (coord_t'(1) << (int'(cfg.log_w) + 3)) - 1'b1;
assign mask_h = (coord_t'(1) << (int'(cfg.log_h) + 3)) - 1'b1;
assign px = (beam_x_i + cfg.scroll_x) & mask_w;
assign py = (beam_y_i + cfg.scroll_y) & mask_h;

// Map entries are halfwords, row-major with 1 << log_w entries per row
assign map_idx = (mem_addr_t'(py >> 3) << cfg.log_w) + mem_addr_t'(px >> 3);
assign map_addr = cfg.tmbase + (map_idx << 1);

// 128 bytes per 8x8 tile, 16 bytes per tile row
assign tile_addr = cfg.tsbase + mem_addr_t'({mem_rdata_i[7:0], fine_y_q, fine_x_q, 1'b0});
assign tile_px = rgb555_t'(mem_rdata_i);

// --------------------
// Fetch FSM

assign start = state == S_MAP && !mem_req_vld_o && !rsp_wait && running_i && cfg.bg_en;
assign map_rsp = state == S_MAP && rsp_wait && mem_rsp_vld_i;
assign tile_rsp = state == S_TILE && rsp_wait && mem_rsp_vld_i;

always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		state <= S_MAP;
		mem_req_vld_o <= 1'b0;
		rsp_wait <= 1'b0;
		pix_vld_o <= 1'b0;
	end else begin
		if (mem_req_vld_o && mem_req_rdy_i) begin
			mem_req_vld_o <= 1'b0;
			rsp_wait <= 1'b1;
		end
		case (state)
		S_MAP: begin
			if (start)
				mem_req_vld_o <= 1'b1;
			if (map_rsp) begin
				mem_req_vld_o <= 1'b1;
				rsp_wait <= 1'b0;
				state <= S_TILE;
			end
		end
		S_TILE: begin
			if (tile_rsp) begin
				rsp_wait <= 1'b0;
				pix_vld_o <= 1'b1;
				state <= S_OUT;
			end
		end
		default: begin
			if (pix_rdy_i) begin
				pix_vld_o <= 1'b0;
				state <= S_MAP;
			end
		end
		endcase
	end
end

// Address and pixel hold steady until their handshakes complete
always_ff @(posedge clk_ppu) begin
	if (start) begin
		mem_addr_o <= map_addr;
		fine_x_q <= px[2:0];
		fine_y_q <= py[2:0];
	end else if (map_rsp) begin
		mem_addr_o <= tile_addr;
	end
	if (tile_rsp)
		pix_o <= tile_px.alpha ? tile_px : '{alpha: 1'b1, colour: cfg.default_bg};
end

endmodule

/* src/ppu_pixel_fifo.sv */
// Pixel FIFO taking background or direct pixels, stored in LCD format
`include "ppu_cfg.svh"

module ppu_pixel_fifo import ppu_pkg::*; (
	input  logic        clk_ppu,
	input  logic        rst_n_ppu,
	input  logic        bg_vld_i,
	output logic        bg_rdy_o,
	input  rgb555_t     bg_pix_i,
	input  logic        direct_vld_i,
	input  lcd_pix_t    direct_pix_i,
	output fifo_level_t level_o,
	output logic        rd_vld_o,
	input  logic        rd_rdy_i,
	output lcd_pix_t    rd_pix_o
);

localparam int W_PTR = $clog2(`PPU_PXFIFO_DEPTH);

lcd_pix_t         mem [`PPU_PXFIFO_DEPTH];
logic [W_PTR-1:0] wr_ptr;
logic [W_PTR-1:0] rd_ptr;
logic             full;
logic             push;
logic             pop;
lcd_pix_t         wdata;
lcd_pix_t         bg_conv;

assign full = level_o == fifo_level_t'(`PPU_PXFIFO_DEPTH);
assign bg_rdy_o = !full && !direct_vld_i;
assign push = !full && (direct_vld_i || bg_vld_i);
assign rd_vld_o = level_o != '0;
assign pop = rd_vld_o && rd_rdy_i;

// RGB555 to panel format, green gets a zero LSB
assign bg_conv = '{r: bg_pix_i.colour.r, g: {bg_pix_i.colour.g, 1'b0}, b: bg_pix_i.colour.b};
assign wdata = direct_vld_i ? direct_pix_i : bg_conv;
assign rd_pix_o = mem[rd_ptr];

always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		level_o <= '0;
	end else begin
		if (push)
			wr_ptr <= wr_ptr == W_PTR'(`PPU_PXFIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr == W_PTR'(`PPU_PXFIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
		if (push && !pop)
			level_o <= level_o + 1'b1;
		else if (pop && !push)
			level_o <= level_o - 1'b1;
	end
end

always_ff @(posedge clk_ppu) begin
	if (push)
		mem[wr_ptr] <= wdata;
end

endmodule

/* src/ppu_dispctrl.sv */
// Serial LCD shifter, 16 bits per pixel MSB first over two cycles each
module ppu_dispctrl import ppu_pkg::*; (
	input  logic     clk_ppu,
	input  logic     rst_n_ppu,
	input  logic     pix_vld_i,
	output logic     pix_rdy_o,
	input  lcd_pix_t pix_i,
	output logic     tx_busy_o,
	output logic     lcd_sck_o,
	output logic     lcd_mosi_o
);

logic [4:0]  phase;
logic [15:0] shift;
logic        last;
logic        pop;

// Phase 31 is the final high half of bit 0
assign last = tx_busy_o && phase == 5'd31;

// Next pixel may be taken on the last phase, keeping the stream gapless
assign pix_rdy_o = !tx_busy_o || last;
assign pop = pix_vld_i && pix_rdy_o;

// Even phases drive sck low, odd phases high
assign lcd_sck_o = tx_busy_o && phase[0];
assign lcd_mosi_o = shift[15];

always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		tx_busy_o <= 1'b0;
		phase <= '0;
		shift <= '0;
	end else if (pop) begin
		tx_busy_o <= 1'b1;
		phase <= '0;
		shift <= pix_i;
	end else if (tx_busy_o) begin
		phase <= phase + 1'b1;
		// Move to the next bit after each high half
		if (phase[0])
			shift <= {shift[14:0], 1'b0};
		if (last)
			tx_busy_o <= 1'b0;
	end
end

endmodule

/* src/ppu_top.sv */
// PPU top level joining registers, raster, background, pixel FIFO and LCD shifter
`include "ppu_cfg.svh"

module ppu_top import ppu_pkg::*; (
	input  logic                    clk_ppu,
	input  logic                    rst_n_ppu,
	input  logic                    apb_psel_i,
	input  logic                    apb_penable_i,
	input  logic                    apb_pwrite_i,
	input  logic [`PPU_W_PADDR-1:0] apb_paddr_i,
	input  logic [`PPU_W_DATA-1:0]  apb_pwdata_i,
	output logic [`PPU_W_DATA-1:0]  apb_prdata_o,
	output logic                    apb_pready_o,
	output logic                    apb_pslverr_o,
	output logic                    mem_req_vld_o,
	input  logic                    mem_req_rdy_i,
	output logic [`PPU_W_ADDR-1:0]  mem_addr_o,
	input  logic                    mem_rsp_vld_i,
	input  logic [15:0]             mem_rdata_i,
	output logic                    lcd_cs_o,
	output logic                    lcd_dc_o,
	output logic                    lcd_sck_o,
	output logic                    lcd_mosi_o
);

logic        run;
logic        halt;
logic        running;
coord_t      beam_x;
coord_t      beam_y;
logic        direct_vld;
lcd_pix_t    direct_pix;
fifo_level_t fifo_level;
logic        tx_busy;
logic        bg_vld;
logic        bg_rdy;
rgb555_t     bg_pix;
logic        bg_xfer;
logic        lcd_vld;
logic        lcd_rdy;
lcd_pix_t    lcd_pix;

ppu_cfg_if cfg_if ();

// --------------------
// Control

ppu_regs regs_i (
	.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
	.apb_psel_i (apb_psel_i), .apb_penable_i (apb_penable_i),
	.apb_pwrite_i (apb_pwrite_i), .apb_paddr_i (apb_paddr_i),
	.apb_pwdata_i (apb_pwdata_i), .apb_prdata_o (apb_prdata_o),
	.apb_pready_o (apb_pready_o), .apb_pslverr_o (apb_pslverr_o),
	.cfg (cfg_if), .run_o (run), .halt_o (halt), .running_i (running),
	.beam_x_i (beam_x), .beam_y_i (beam_y),
	.direct_vld_o (direct_vld), .direct_pix_o (direct_pix),
	.fifo_level_i (fifo_level), .tx_busy_i (tx_busy),
	.lcd_cs_o (lcd_cs_o), .lcd_dc_o (lcd_dc_o)
);

// Beam steps once per pixel handed to the FIFO
assign bg_xfer = bg_vld && bg_rdy;

ppu_raster_counter raster_i (
	.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu), .cfg (cfg_if),
	.run_i (run), .halt_i (halt), .step_i (bg_xfer),
	.running_o (running), .beam_x_o (beam_x), .beam_y_o (beam_y)
);

// --------------------
// Pixel path

ppu_background bg_i (
	.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu), .cfg (cfg_if),
	.running_i (running), .beam_x_i (beam_x), .beam_y_i (beam_y),
	.mem_req_vld_o (mem_req_vld_o), .mem_req_rdy_i (mem_req_rdy_i),
	.mem_addr_o (mem_addr_o), .mem_rsp_vld_i (mem_rsp_vld_i),
	.mem_rdata_i (mem_rdata_i),
	.pix_vld_o (bg_vld), .pix_rdy_i (bg_rdy), .pix_o (bg_pix)
);

ppu_pixel_fifo fifo_i (
	.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
	.bg_vld_i (bg_vld), .bg_rdy_o (bg_rdy), .bg_pix_i (bg_pix),
	.direct_vld_i (direct_vld), .direct_pix_i (direct_pix),
	.level_o (fifo_level),
	.rd_vld_o (lcd_vld), .rd_rdy_i (lcd_rdy), .rd_pix_o (lcd_pix)
);

ppu_dispctrl dispctrl_i (
	.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
	.pix_vld_i (lcd_vld), .pix_rdy_o (lcd_rdy), .pix_i (lcd_pix),
	.tx_busy_o (tx_busy), .lcd_sck_o (lcd_sck_o), .lcd_mosi_o (lcd_mosi_o)
);

endmodule

/* verif/ppu_checker.sv */
// Bound assertions on the PPU memory port, APB ready and reset state of the outputs
`include "ppu_cfg.svh"

module ppu_checker (
	input logic                   clk_ppu,
	input logic                   rst_n_ppu,
	input logic                   apb_pready_o,
	input logic                   mem_req_vld_o,
	input logic                   mem_req_rdy_i,
	input logic [`PPU_W_ADDR-1:0] mem_addr_o,
	input logic                   mem_rsp_vld_i,
	input logic                   lcd_sck_o
);

int   fail_cnt = 0;
logic pend;

// One accepted request waiting for its response
always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
	if (!rst_n_ppu) begin
		pend <= 1'b0;
	end else if (mem_req_vld_o && mem_req_rdy_i) begin
		pend <= 1'b1;
	end else if (mem_rsp_vld_i) begin
		pend <= 1'b0;
	end
end

req_stable_a: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
	mem_req_vld_o && !mem_req_rdy_i |=> mem_req_vld_o && $stable(mem_addr_o))
	else begin
		$error("memory request dropped or changed while stalled");
		fail_cnt++;
	end

one_outstanding_a: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
	mem_req_vld_o |-> !pend)
	else begin
		$error("second memory request before the response");
		fail_cnt++;
	end

pready_a: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu) apb_pready_o)
	else begin
		$error("APB pready low");
		fail_cnt++;
	end

reset_state_a: assert property (@(posedge clk_ppu)
	!rst_n_ppu |-> !lcd_sck_o && !mem_req_vld_o)
	else begin
		$error("sck or memory request active in reset");
		fail_cnt++;
	end

endmodule

bind ppu_top ppu_checker chk_i (
	.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu), .apb_pready_o (apb_pready_o),
	.mem_req_vld_o (mem_req_vld_o), .mem_req_rdy_i (mem_req_rdy_i),
	.mem_addr_o (mem_addr_o), .mem_rsp_vld_i (mem_rsp_vld_i), .lcd_sck_o (lcd_sck_o)
);

/* verif/ppu_tb.sv */
// PPU testbench with APB driver, memory model, LCD capture and pixel reference model
`include "ppu_cfg.svh"

module ppu_tb import ppu_pkg::*; ();

logic                    clk_ppu = 1'b0;
logic                    rst_n_ppu;
logic                    apb_psel_i;
logic                    apb_penable_i;
logic                    apb_pwrite_i;
logic [`PPU_W_PADDR-1:0] apb_paddr_i;
logic [`PPU_W_DATA-1:0]  apb_pwdata_i;
logic [`PPU_W_DATA-1:0]  apb_prdata_o;
logic                    apb_pready_o;
logic                    apb_pslverr_o;
logic                    mem_req_vld_o;
logic                    mem_req_rdy_i;
logic [`PPU_W_ADDR-1:0]  mem_addr_o;
logic                    mem_rsp_vld_i;
logic [15:0]             mem_rdata_i;
logic                    lcd_cs_o;
logic                    lcd_dc_o;
logic                    lcd_sck_o;
logic                    lcd_mosi_o;

int          seed = 32'hcac7c092;
int          reg_errs = 0;
int          pix_errs = 0;
int          tmo_errs = 0;
logic [15:0] mem_arr [32768];
lcd_pix_t    rx_q[$];
lcd_pix_t    exp_q[$];

// Frame settings shared with the reference model
int          lw;
int          lh;
logic [11:0] scx;
logic [11:0] scy;
logic [15:0] tsbase;
logic [15:0] tmbase;
logic [14:0] dflt;

ppu_top dut_i (.*);

always #50 clk_ppu = ~clk_ppu;

// --------------------
// Memory model

logic        pend = 1'b0;
logic [15:0] pend_addr;
int          lat;
logic [31:0] mem_rnd;
logic [31:0] rdy_rnd;

always @(negedge clk_ppu) begin
	if (rst_n_ppu && mem_req_vld_o && mem_req_rdy_i) begin
		pend = 1'b1;
		pend_addr = mem_addr_o;
		mem_rnd = $random(seed);
		lat = int'(mem_rnd[1:0]);
	end
end

always @(posedge clk_ppu) begin
	#10;
	mem_rsp_vld_i = 1'b0;
	if (pend && lat == 0) begin
		mem_rsp_vld_i = 1'b1;
		mem_rdata_i = mem_arr[pend_addr[15:1]];
		pend = 1'b0;
	end else if (pend) begin
		lat--;
	end
	rdy_rnd = $random(seed);
	mem_req_rdy_i = rdy_rnd[1:0] != 2'b00;
end

// LCD capture, one bit per rising sck
logic [15:0] rx_word = '0;
int          rx_bits = 0;

always @(posedge lcd_sck_o) begin
	rx_word = {rx_word[14:0], lcd_mosi_o};
	rx_bits++;
	if (rx_bits == 16) begin
		rx_q.push_back(lcd_pix_t'(rx_word));
		rx_bits = 0;
	end
end

// --------------------
// APB driver and checks

task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
	int n;
	@(posedge clk_ppu);
	#10;
	apb_psel_i = 1'b1;
	apb_penable_i = 1'b0;
	apb_pwrite_i = wr;
	apb_paddr_i = addr;
	apb_pwdata_i = wdata;
	@(posedge clk_ppu);
	#10;
	apb_penable_i = 1'b1;
	n = 0;
	@(negedge clk_ppu);
	while (!apb_pready_o && n < 16) begin
		@(negedge clk_ppu);
		n++;
	end
	if (!apb_pready_o) begin
		tmo_errs++;
		$display("APB access to %h never got pready", addr);
	end
	rdata = apb_prdata_o;
	err = apb_pslverr_o;
	@(posedge clk_ppu);
	#10;
	apb_psel_i = 1'b0;
	apb_penable_i = 1'b0;
	apb_pwrite_i = 1'b0;
endtask

task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata);
	logic [31:0] rd;
	logic        err;
	apb_access(1'b1, addr, wdata, rd, err);
endtask

task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata, output logic err);
	apb_access(1'b0, addr, '0, rdata, err);
endtask

task automatic check_reg(input string what, input logic [`PPU_W_DATA-1:0] got,
		input logic [`PPU_W_DATA-1:0] want);
	if (got !== want) begin
		reg_errs++;
		$display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, want);
	end
endtask

task automatic check_pix(input string what, input lcd_pix_t got, input lcd_pix_t want);
	if (got !== want) begin
		pix_errs++;
		$display("FAIL t=%0t %s: got pixel %h, expected %h", $time, what, got, want);
	end
endtask

task automatic write_readback(input logic [15:0] addr, input logic [31:0] mask, input string what);
	logic [31:0] wd;
	logic [31:0] rd;
	logic        err;
	wd = $random(seed) & mask;
	apb_write(addr, wd);
	apb_read(addr, rd, err);
	check_reg(what, rd, wd);
	check_reg({what, " pslverr"}, {31'b0, err}, 32'd0);
endtask

task automatic wait_halted();
	logic [31:0] rd;
	logic        err;
	int          n;
	n = 0;
	rd = 32'h4;
	while (rd[2] && n < 3000) begin
		apb_read(`PPU_REG_CSR, rd, err);
		n++;
	end
	if (rd[2]) begin
		tmo_errs++;
		$display("Timeout: PPU still running long after the frame should have ended");
	end
endtask

task automatic wait_drained();
	logic [31:0] rd;
	logic        err;
	int          n;
	n = 0;
	rd = '0;
	while (rd[6:4] != 3'b001 && n < 3000) begin
		apb_read(`PPU_REG_PXFIFO, rd, err);
		n++;
	end
	if (rd[6:4] != 3'b001) begin
		tmo_errs++;
		$display("Timeout: pixel FIFO and serial output never went idle");
	end
endtask

task automatic compare_output(input string what);
	lcd_pix_t got;
	lcd_pix_t want;
	check_reg({what, " pixel count"}, 32'(rx_q.size()), 32'(exp_q.size()));
	while (rx_q.size() > 0 && exp_q.size() > 0) begin
		got = rx_q.pop_front();
		want = exp_q.pop_front();
		check_pix(what, got, want);
	end
	rx_q.delete();
	exp_q.delete();
endtask

// --------------------
// Reference model

function automatic lcd_pix_t ref_pixel(int x, int y);
	int          px;
	int          py;
	int          idx;
	logic [15:0] a;
	logic [15:0] d;
	logic [14:0] c;
	px = (x + int'(scx)) % (8 << lw);
	py = (y + int'(scy)) % (8 << lh);
	a = tmbase + 16'(2 * ((py / 8) * (1 << lw) + px / 8));
	idx = int'(mem_arr[a[15:1]][7:0]);
	a = tsbase + 16'(128 * idx + 16 * (py % 8) + 2 * (px % 8));
	d = mem_arr[a[15:1]];
	// Transparent texels take the default colour
	c = d[15] ? d[14:0] : dflt;
	return '{r: c[14:10], g: {c[9:5], 1'b0}, b: c[4:0]};
endfunction

// --------------------
// Test sequence

initial begin
	logic [31:0] rnd;
	logic [31:0] rd;
	logic        err;
	int          w;
	int          h;
	rst_n_ppu = 1'b0;
	apb_psel_i = 1'b0;
	apb_penable_i = 1'b0;
	apb_pwrite_i = 1'b0;
	apb_paddr_i = '0;
	apb_pwdata_i = '0;
	mem_req_rdy_i = 1'b0;
	mem_rsp_vld_i = 1'b0;
	mem_rdata_i = '0;
	for (int i = 0; i < 32768; i++) begin
		rnd = $random(seed);
		mem_arr[i] = rnd[15:0];
	end
	repeat (4) @(posedge clk_ppu);
	#10;
	rst_n_ppu = 1'b1;
	@(negedge clk_ppu);
	check_reg("lcd_cs after reset", {31'b0, lcd_cs_o}, 32'd1);
	check_reg("lcd_sck after reset", {31'b0, lcd_sck_o}, 32'd0);
	check_reg("mem_req_vld after reset", {31'b0, mem_req_vld_o}, 32'd0);

	// Register readback and unmapped offsets
	for (int i = 0; i < 3; i++) begin
		write_readback(`PPU_REG_CSR, 32'h38, "CSR");
		write_readback(`PPU_REG_DISPSIZE, 32'h0fff_0fff, "DISPSIZE");
		write_readback(`PPU_REG_DEFAULT_BG, 32'h7fff, "DEFAULT_BG");
		write_readback(`PPU_REG_BG_CSR, 32'h0ff1, "BG_CSR");
		write_readback(`PPU_REG_SCROLL, 32'h0fff_0fff, "SCROLL");
		write_readback(`PPU_REG_TSBASE, 32'hffff, "TSBASE");
		write_readback(`PPU_REG_TMBASE, 32'hffff, "TMBASE");
	end
	apb_read(16'h0024, rd, err);
	check_reg("pslverr at 0x24", {31'b0, err}, 32'd1);
	apb_read(16'h0100, rd, err);
	check_reg("pslverr at 0x100", {31'b0, err}, 32'd1);

	// Panel select and data/command pins follow CSR bits 4 and 5
	for (int i = 0; i < 4; i++) begin
		apb_write(`PPU_REG_CSR, 32'(i) << 4);
		check_reg("lcd_cs pin", {31'b0, lcd_cs_o}, 32'(i % 2));
		check_reg("lcd_dc pin", {31'b0, lcd_dc_o}, 32'(i / 2));
	end

	// Direct pushes while stopped
	apb_write(`PPU_REG_CSR, 32'h0);
	for (int i = 0; i < 5; i++) begin
		rnd = $random(seed);
		exp_q.push_back(lcd_pix_t'(rnd[15:0]));
		apb_write(`PPU_REG_PXFIFO, rnd);
		if (i == 0) begin
			apb_read(`PPU_REG_PXFIFO, rd, err);
			check_reg("tx busy while shifting", rd & 32'h40, 32'h40);
		end
	end
	wait_drained();
	compare_output("direct push");

	// Random frames, halted at vsync
	for (int f = 0; f < 4; f++) begin
		rnd = $random(seed);
		w = 3 + int'(rnd[2:0]) % 6;
		h = 2 + int'(rnd[5:4]) % 3;
		lw = int'(rnd[9:8]) % 3;
		lh = int'(rnd[13:12]) % 3;
		rnd = $random(seed);
		scx = rnd[11:0];
		scy = rnd[27:16];
		rnd = $random(seed);
		tsbase = {rnd[15:1], 1'b0};
		tmbase = {rnd[31:17], 1'b0};
		rnd = $random(seed);
		dflt = rnd[14:0];
		apb_write(`PPU_REG_DISPSIZE, {4'b0, 12'(h), 4'b0, 12'(w)});
		apb_write(`PPU_REG_BG_CSR, {20'b0, 4'(lh), 4'(lw), 4'b0001});
		apb_write(`PPU_REG_SCROLL, {4'b0, scy, 4'b0, scx});
		apb_write(`PPU_REG_TSBASE, {16'b0, tsbase});
		apb_write(`PPU_REG_TMBASE, {16'b0, tmbase});
		apb_write(`PPU_REG_DEFAULT_BG, {17'b0, dflt});
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				exp_q.push_back(ref_pixel(x, y));
			end
		end
		// Run with halt at end of frame
		apb_write(`PPU_REG_CSR, 32'h09);
		wait_halted();
		apb_read(`PPU_REG_BEAM, rd, err);
		check_reg("beam after frame", rd, 32'h0);
		wait_drained();
		compare_output("frame");
	end

	$display("Errors: register %0d, pixel %0d, timeout %0d, assertion %0d",
		reg_errs, pix_errs, tmo_errs, dut_i.chk_i.fail_cnt);
	if (reg_errs + pix_errs + tmo_errs + dut_i.chk_i.fail_cnt == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule

/* tb.f */
+incdir+src
src/ppu_pkg.sv
src/ppu_cfg_if.sv
src/ppu_regs.sv
src/ppu_raster_counter.sv
src/ppu_background.sv
src/ppu_pixel_fifo.sv
src/ppu_dispctrl.sv
src/ppu_top.sv
verif/ppu_checker.sv
verif/ppu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module ppu_tb -o ppu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ppu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
